/* list.f */
verilog/refill_pkg.sv
verilog/refill_fifo.sv
verilog/credit_counter.sv
verilog/refill_fsm.sv
verilog/line_assembler.sv
verilog/icache_refill_bridge.sv
tb/bus_mem_model.sv
tb/tb_refill_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build the refill bridge testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_refill_bridge -f list.f -o sim_refill \
  && ./obj_dir/sim_refill > sim.log 2>&1 \
  || { echo "Build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "Result: FAIL"; exit 1; } \
  || { echo "Result: PASS"; exit 0; }

/* tb/tb_refill_bridge.sv */
/*
 * Testbench for the refill bridge with clock, reset, stimulus table,
 * in-order scoreboard, credit monitor and timeout
 */

`timescale 1ns/1ps
`default_nettype none

module tb_refill_bridge;

  import refill_pkg::*;

  localparam int          NUM_TESTS         = 8;
  localparam int          HOLD_CYCLES       = 40;
  localparam int          CREDIT_DELAY_BITS = 4;
  localparam int          DATA_DELAY_BITS   = 3;
  localparam logic [31:0] DATA_PATTERN      = 32'hc3a5_5a3c;
  localparam int          WORST_BURST       = (1 << CREDIT_DELAY_BITS) + (1 << DATA_DELAY_BITS)
                                              + BEATS_PER_LINE + 8;
  localparam int          CYCLE_LIMIT       = 16 + NUM_TESTS * (WORST_BURST + HOLD_CYCLES) + 64;

  // Columns are miss address, bypass flag, tid and hold of rtrn_ready_i
  localparam logic [ADDR_WIDTH-1:0] TEST_ADDR [NUM_TESTS] = '{
    32'h0000_1000, 32'h0000_2346, 32'h8000_0a5c, 32'h1234_5678,
    32'h0000_0fff, 32'hdead_bee0, 32'h4000_0010, 32'h7fff_fff3
  };
  localparam logic                 TEST_NC   [NUM_TESTS] = '{
    1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1
  };
  localparam logic [TID_WIDTH-1:0] TEST_TID  [NUM_TESTS] = '{
    2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd1, 2'd2, 2'd3
  };
  localparam logic                 TEST_HOLD [NUM_TESTS] = '{
    1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0
  };

  logic                      clk_i;
  logic                      rst_ni;
  logic                      miss_valid_i;
  logic                      miss_ready_o;
  logic [ADDR_WIDTH-1:0]     miss_paddr_i;
  logic                      miss_nc_i;
  logic [TID_WIDTH-1:0]      miss_tid_i;
  logic                      rtrn_valid_o;
  logic                      rtrn_ready_i;
  logic [LINE_WIDTH-1:0]     rtrn_data_o;
  logic [TID_WIDTH-1:0]      rtrn_tid_o;
  logic                      bus_req_valid_o;
  logic [ADDR_WIDTH-1:0]     bus_req_addr_o;
  logic [BEAT_CNT_WIDTH-1:0] bus_req_len_o;
  logic [TID_WIDTH-1:0]      bus_req_id_o;
  logic                      bus_credit_i;
  logic                      bus_rd_valid_i;
  logic [BUS_DATA_WIDTH-1:0] bus_rd_data_i;
  logic                      bus_rd_last_i;

  // Scoreboard queues filled in acceptance order
  logic [LINE_WIDTH-1:0]     exp_line_q[$];
  logic [TID_WIDTH-1:0]      exp_tid_q[$];
  logic [ADDR_WIDTH-1:0]     exp_addr_q[$];
  logic [BEAT_CNT_WIDTH-1:0] exp_len_q[$];
  logic [TID_WIDTH-1:0]      exp_id_q[$];

  int   errors;
  int   tests_passed;
  int   tests_failed;
  int   issued;
  int   credits_returned;
  int   cycles;
  logic stall_seen;

  icache_refill_bridge i_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .miss_valid_i    (miss_valid_i),
    .miss_ready_o    (miss_ready_o),
    .miss_paddr_i    (miss_paddr_i),
    .miss_nc_i       (miss_nc_i),
    .miss_tid_i      (miss_tid_i),
    .rtrn_valid_o    (rtrn_valid_o),
    .rtrn_ready_i    (rtrn_ready_i),
    .rtrn_data_o     (rtrn_data_o),
    .rtrn_tid_o      (rtrn_tid_o),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_addr_o  (bus_req_addr_o),
    .bus_req_len_o   (bus_req_len_o),
    .bus_req_id_o    (bus_req_id_o),
    .bus_credit_i    (bus_credit_i),
    .bus_rd_valid_i  (bus_rd_valid_i),
    .bus_rd_data_i   (bus_rd_data_i),
    .bus_rd_last_i   (bus_rd_last_i)
  );

  bus_mem_model #(
    .CREDIT_DELAY_BITS (CREDIT_DELAY_BITS),
    .DATA_DELAY_BITS   (DATA_DELAY_BITS),
    .DATA_PATTERN      (DATA_PATTERN)
  ) i_bus_mem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (bus_req_valid_o),
    .req_addr_i  (bus_req_addr_o),
    .req_len_i   (bus_req_len_o),
    .credit_o    (bus_credit_i),
    .rd_valid_o  (bus_rd_valid_i),
    .rd_data_o   (bus_rd_data_i),
    .rd_last_o   (bus_rd_last_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      errors++;
    end
  endtask

  // Word aligned for bypass and line aligned otherwise
  function automatic logic [ADDR_WIDTH-1:0] align_addr(input logic [ADDR_WIDTH-1:0] addr,
                                                       input logic nc);
    return nc ? {addr[ADDR_WIDTH-1:2], 2'b00} : {addr[ADDR_WIDTH-1:4], 4'b0000};
  endfunction

  function automatic logic [LINE_WIDTH-1:0] predict_line(input logic [ADDR_WIDTH-1:0] addr,
                                                         input logic nc);
    logic [LINE_WIDTH-1:0] line;
    logic [ADDR_WIDTH-1:0] base;
    int                    k;
    line = '0;
    base = align_addr(addr, nc);
    for (k = 0; k < (nc ? 1 : BEATS_PER_LINE); k++) begin
      line[k*BUS_DATA_WIDTH +: BUS_DATA_WIDTH] = (base + ADDR_WIDTH'(4 * k)) ^ DATA_PATTERN;
    end
    return line;
  endfunction

  task automatic send_miss(input int idx);
    miss_valid_i = 1'b1;
    miss_paddr_i = TEST_ADDR[idx];
    miss_nc_i    = TEST_NC[idx];
    miss_tid_i   = TEST_TID[idx];
    while (!miss_ready_o) begin
      @(negedge clk_i);
    end
    // Accepted on the coming rising edge
    exp_line_q.push_back(predict_line(TEST_ADDR[idx], TEST_NC[idx]));
    exp_tid_q.push_back(TEST_TID[idx]);
    exp_addr_q.push_back(align_addr(TEST_ADDR[idx], TEST_NC[idx]));
    exp_len_q.push_back(TEST_NC[idx] ? 2'd0 : BEAT_CNT_WIDTH'(BEATS_PER_LINE - 1));
    exp_id_q.push_back(TEST_TID[idx]);
    @(negedge clk_i);
  endtask

  task automatic collect_line(input int idx);
    logic [LINE_WIDTH-1:0] held_data;
    logic [TID_WIDTH-1:0]  held_tid;
    int                    errors_before;
    errors_before = errors;
    @(negedge clk_i);
    if (TEST_HOLD[idx]) begin
      rtrn_ready_i = 1'b0;
    end
    while (!rtrn_valid_o) begin
      @(negedge clk_i);
    end
    if (TEST_HOLD[idx]) begin
      held_data = rtrn_data_o;
      held_tid  = rtrn_tid_o;
      repeat (HOLD_CYCLES) begin
        @(negedge clk_i);
        check_value("rtrn_valid_o", 128'(rtrn_valid_o), 128'(1'b1));
        check_value("rtrn_data_o", rtrn_data_o, held_data);
        check_value("rtrn_tid_o", 128'(rtrn_tid_o), 128'(held_tid));
        if (!miss_ready_o) begin
          stall_seen = 1'b1;
        end
      end
      rtrn_ready_i = 1'b1;
    end
    if (exp_line_q.size() == 0) begin
      $display("Line returned for test %0d while no miss was outstanding", idx);
      errors++;
    end else begin
      check_value("rtrn_data_o", rtrn_data_o, exp_line_q.pop_front());
      check_value("rtrn_tid_o", 128'(rtrn_tid_o), 128'(exp_tid_q.pop_front()));
    end
    if (errors == errors_before) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("test %0d %s 0x%h tid %0d: %s", idx, TEST_NC[idx] ? "bypass" : "cacheable",
             TEST_ADDR[idx], TEST_TID[idx], (errors == errors_before) ? "passed" : "FAILED");
  endtask

  always @(posedge clk_i) begin
    if (rst_ni && bus_credit_i) begin
      credits_returned++;
    end
  end

  // Bus request monitor checking the credit limit and the request fields
  always @(negedge clk_i) begin
    if (rst_ni && bus_req_valid_o) begin
      issued++;
      if (issued > BUS_CREDITS + credits_returned) begin
        $display("Bus request %0d issued without a credit", issued);
        errors++;
      end
      if (exp_addr_q.size() == 0) begin
        $display("Bus request seen with no miss outstanding");
        errors++;
      end else begin
        check_value("bus_req_addr_o", 128'(bus_req_addr_o), 128'(exp_addr_q.pop_front()));
        check_value("bus_req_len_o", 128'(bus_req_len_o), 128'(exp_len_q.pop_front()));
        check_value("bus_req_id_o", 128'(bus_req_id_o), 128'(exp_id_q.pop_front()));
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    errors           = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    issued           = 0;
    credits_returned = 0;
    stall_seen       = 1'b0;
    rst_ni           = 1'b0;
    miss_valid_i     = 1'b0;
    miss_paddr_i     = '0;
    miss_nc_i        = 1'b0;
    miss_tid_i       = '0;
    rtrn_ready_i     = 1'b1;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("rtrn_valid_o", 128'(rtrn_valid_o), 128'(1'b0));
    check_value("bus_req_valid_o", 128'(bus_req_valid_o), 128'(1'b0));
    check_value("miss_ready_o", 128'(miss_ready_o), 128'(1'b1));
    $display("reset values: %s", (errors == 0) ? "passed" : "FAILED");
    fork
      begin
        for (int i = 0; i < NUM_TESTS; i++) begin
          send_miss(i);
        end
        miss_valid_i = 1'b0;
      end
      begin
        for (int j = 0; j < NUM_TESTS; j++) begin
          collect_line(j);
        end
      end
    join
    repeat (4) @(negedge clk_i);
    check_value("bus request count", 128'(issued), 128'(NUM_TESTS));
    if (!stall_seen) begin
      $display("miss_ready_o never dropped while returns were held back");
      errors++;
    end
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/bus_mem_model.sv */
/*
 * Behavioral memory bus slave: credit return, random response delays
 * and read data derived from the beat address
 */

`timescale 1ns/1ps
`default_nettype none

module bus_mem_model #(
  parameter int          CREDIT_DELAY_BITS = 4,
  parameter int          DATA_DELAY_BITS   = 3,
  parameter logic [31:0] DATA_PATTERN      = 32'h0
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic                                  req_valid_i,
  input  wire logic [refill_pkg::ADDR_WIDTH-1:0]     req_addr_i,
  input  wire logic [refill_pkg::BEAT_CNT_WIDTH-1:0] req_len_i,
  output logic                                       credit_o,
  output logic                                       rd_valid_o,
  output logic [refill_pkg::BUS_DATA_WIDTH-1:0]      rd_data_o,
  output logic                                       rd_last_o
);

  import refill_pkg::*;

  logic [31:0]               lfsr_q;
  int                        cycle;
  int                        credit_due_q[$];
  logic [ADDR_WIDTH-1:0]     addr_q[$];
  logic [BEAT_CNT_WIDTH-1:0] len_q[$];
  logic                      busy;
  int                        wait_cnt;
  int                        beat;
  int                        delay;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output int value);
    value = 0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
  endtask

  initial begin
    lfsr_q     = 32'd94254;
    cycle      = 0;
    busy       = 1'b0;
    wait_cnt   = 0;
    beat       = 0;
    delay      = 0;
    credit_o   = 1'b0;
    rd_valid_o = 1'b0;
    rd_data_o  = '0;
    rd_last_o  = 1'b0;
    forever begin
      @(negedge clk_i);
      cycle++;
      credit_o   = 1'b0;
      rd_valid_o = 1'b0;
      rd_last_o  = 1'b0;
      if (!rst_ni) begin
        busy = 1'b0;
        credit_due_q.delete();
        addr_q.delete();
        len_q.delete();
      end else begin
        // Beats never start on the cycle the request is seen
        if (busy) begin
          if (wait_cnt > 0) begin
            wait_cnt--;
          end else begin
            rd_valid_o = 1'b1;
            rd_data_o  = (addr_q[0] + ADDR_WIDTH'(4 * beat)) ^ DATA_PATTERN;
            if (beat == int'(len_q[0])) begin
              rd_last_o = 1'b1;
              busy      = 1'b0;
              void'(addr_q.pop_front());
              void'(len_q.pop_front());
            end else begin
              beat++;
            end
          end
        end else if (addr_q.size() > 0) begin
          busy = 1'b1;
          beat = 0;
          draw_bits(DATA_DELAY_BITS, wait_cnt);
        end
        if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
          credit_o = 1'b1;
          void'(credit_due_q.pop_front());
        end
        if (req_valid_i) begin
          addr_q.push_back(req_addr_i);
          len_q.push_back(req_len_i);
          draw_bits(CREDIT_DELAY_BITS, delay);
          credit_due_q.push_back(cycle + 1 + delay);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_refill_bridge.sv */
/*
 * Instruction-cache refill bridge top: miss queue, credit counter,
 * refill FSM, line assembler and return queue
 */

`timescale 1ns/1ps
`default_nettype none

module icache_refill_bridge (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  // Miss input from the fetch unit
  input  wire logic                                  miss_valid_i,
  output logic                                       miss_ready_o,
  input  wire logic [refill_pkg::ADDR_WIDTH-1:0]     miss_paddr_i,
  input  wire logic                                  miss_nc_i,
  input  wire logic [refill_pkg::TID_WIDTH-1:0]      miss_tid_i,
  // Line return to the fetch unit
  output logic                                       rtrn_valid_o,
  input  wire logic                                  rtrn_ready_i,
  output logic [refill_pkg::LINE_WIDTH-1:0]          rtrn_data_o,
  output logic [refill_pkg::TID_WIDTH-1:0]           rtrn_tid_o,
  // Bus request channel
  output logic                                       bus_req_valid_o,
  output logic [refill_pkg::ADDR_WIDTH-1:0]          bus_req_addr_o,
  output logic [refill_pkg::BEAT_CNT_WIDTH-1:0]      bus_req_len_o,
  output logic [refill_pkg::TID_WIDTH-1:0]           bus_req_id_o,
  input  wire logic                                  bus_credit_i,
  // Bus read data channel
  input  wire logic                                  bus_rd_valid_i,
  input  wire logic [refill_pkg::BUS_DATA_WIDTH-1:0] bus_rd_data_i,
  input  wire logic                                  bus_rd_last_i
);

  import refill_pkg::*;

  miss_req_t             miss_in;
  miss_req_t             miss_out;
  logic                  miss_full;
  logic                  miss_empty;
  logic                  miss_pop;
  line_rtrn_t            rtrn_in;
  line_rtrn_t            rtrn_out;
  logic                  rtrn_full;
  logic                  rtrn_empty;
  logic                  rtrn_push;
  logic [TID_WIDTH-1:0]  rtrn_tid;
  logic                  has_credit;
  logic                  issue;
  logic                  start;
  logic                  nc;
  logic                  line_done;
  logic [LINE_WIDTH-1:0] line;

  assign miss_in.paddr = miss_paddr_i;
  assign miss_in.nc    = miss_nc_i;
  assign miss_in.tid   = miss_tid_i;
  assign miss_ready_o  = !miss_full;

  refill_fifo #(
    .payload_t (miss_req_t),
    .DEPTH     (QUEUE_DEPTH)
  ) i_miss_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (miss_valid_i),
    .data_i  (miss_in),
    .full_o  (miss_full),
    .pop_i   (miss_pop),
    .data_o  (miss_out),
    .empty_o (miss_empty)
  );

  credit_counter i_credit_counter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .credit_i     (bus_credit_i),
    .has_credit_o (has_credit)
  );

  refill_fsm i_refill_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .miss_empty_i    (miss_empty),
    .miss_data_i     (miss_out),
    .miss_pop_o      (miss_pop),
    .has_credit_i    (has_credit),
    .issue_o         (issue),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_addr_o  (bus_req_addr_o),
    .bus_req_len_o   (bus_req_len_o),
    .bus_req_id_o    (bus_req_id_o),
    .start_o         (start),
    .nc_o            (nc),
    .line_done_i     (line_done),
    .rtrn_full_i     (rtrn_full),
    .rtrn_push_o     (rtrn_push),
    .rtrn_tid_o      (rtrn_tid)
  );

  line_assembler i_line_assembler (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start),
    .nc_i        (nc),
    .rd_valid_i  (bus_rd_valid_i),
    .rd_data_i   (bus_rd_data_i),
    .rd_last_i   (bus_rd_last_i),
    .line_o      (line),
    .line_done_o (line_done)
  );

  assign rtrn_in.data = line;
  assign rtrn_in.tid  = rtrn_tid;

  refill_fifo #(
    .payload_t (line_rtrn_t),
    .DEPTH     (QUEUE_DEPTH)
  ) i_rtrn_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rtrn_push),
    .data_i  (rtrn_in),
    .full_o  (rtrn_full),
    .pop_i   (rtrn_ready_i),
    .data_o  (rtrn_out),
    .empty_o (rtrn_empty)
  );

  assign rtrn_valid_o = !rtrn_empty;
  assign rtrn_data_o  = rtrn_out.data;
  assign rtrn_tid_o   = rtrn_out.tid;

endmodule

`default_nettype wire

/* verilog/line_assembler.sv */
/*
 * Line assembler: beat counter and line buffer,
 * drops each read beat into its word slot
 */

`timescale 1ns/1ps
`default_nettype none

module line_assembler (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              start_i,
  input  wire logic                              nc_i,
  input  wire logic                              rd_valid_i,
  input  wire logic [refill_pkg::BUS_DATA_WIDTH-1:0] rd_data_i,
  input  wire logic                              rd_last_i,
  output logic [refill_pkg::LINE_WIDTH-1:0]      line_o,
  output logic                                   line_done_o
);

  import refill_pkg::*;

  logic [BEATS_PER_LINE-1:0][BUS_DATA_WIDTH-1:0] line_q;
  logic [BEAT_CNT_WIDTH-1:0]                     beat_cnt_q;
  logic                                          nc_q;
  logic                                          line_done_q;
  logic [BEAT_CNT_WIDTH-1:0]                     slot;

  // Bypass data always sits in word 0
  assign slot = nc_q ? '0 : beat_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q  <= '0;
      nc_q        <= 1'b0;
      line_done_q <= 1'b0;
    end else begin
      line_done_q <= 1'b0;
      if (start_i) begin
        beat_cnt_q <= '0;
        nc_q       <= nc_i;
      end else if (rd_valid_i) begin
        beat_cnt_q  <= beat_cnt_q + 1'b1;
        line_done_q <= rd_last_i || nc_q;
      end
    end
  end

  // Words not written by this burst read back as zero
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      line_q <= '0;
    end else if (rd_valid_i) begin
      line_q[slot] <= rd_data_i;
    end
  end

  assign line_o      = line_q;
  assign line_done_o = line_done_q;

endmodule

`default_nettype wire

/* verilog/refill_fsm.sv */
/*
 * Refill FSM: takes a queued miss, issues one aligned burst,
 * starts the line assembler and pushes the finished line
 */

`timescale 1ns/1ps
`default_nettype none

module refill_fsm (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  // Miss queue side
  input  wire logic                                 miss_empty_i,
  input  refill_pkg::miss_req_t                     miss_data_i,
  output logic                                      miss_pop_o,
  // Credit counter
  input  wire logic                                 has_credit_i,
  output logic                                      issue_o,
  // Bus request
  output logic                                      bus_req_valid_o,
  output logic [refill_pkg::ADDR_WIDTH-1:0]         bus_req_addr_o,
  output logic [refill_pkg::BEAT_CNT_WIDTH-1:0]     bus_req_len_o,
  output logic [refill_pkg::TID_WIDTH-1:0]          bus_req_id_o,
  // Line assembler
  output logic                                      start_o,
  output logic                                      nc_o,
  input  wire logic                                 line_done_i,
  // Return queue side
  input  wire logic                                 rtrn_full_i,
  output logic                                      rtrn_push_o,
  output logic [refill_pkg::TID_WIDTH-1:0]          rtrn_tid_o
);

  import refill_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT
  } state_e;

  state_e                    state_q;
  state_e                    state_d;
  logic [ADDR_WIDTH-1:0]     addr_q;
  logic [BEAT_CNT_WIDTH-1:0] len_q;
  logic [TID_WIDTH-1:0]      tid_q;
  logic                      nc_q;
  logic                      launch;

  // Only one burst is in flight, so a free slot now is still free at push time
  assign launch = (state_q == IDLE) && !miss_empty_i && has_credit_i && !rtrn_full_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (launch) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        state_d = WAIT;
      end
      WAIT: begin
        if (line_done_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Bypass reads a single word, cacheable reads the whole line
  always_ff @(posedge clk_i) begin
    if (launch) begin
      tid_q <= miss_data_i.tid;
      nc_q  <= miss_data_i.nc;
      if (miss_data_i.nc) begin
        addr_q <= miss_data_i.paddr & ~ADDR_WIDTH'(BUS_DATA_WIDTH / 8 - 1);
        len_q  <= '0;
      end else begin
        addr_q <= miss_data_i.paddr & ~ADDR_WIDTH'(LINE_WIDTH / 8 - 1);
        len_q  <= BEAT_CNT_WIDTH'(BEATS_PER_LINE - 1);
      end
    end
  end

  assign miss_pop_o      = launch;
  assign issue_o         = (state_q == ISSUE);
  assign bus_req_valid_o = (state_q == ISSUE);
  assign bus_req_addr_o  = addr_q;
  assign bus_req_len_o   = len_q;
  assign bus_req_id_o    = tid_q;
  assign start_o         = (state_q == ISSUE);
  assign nc_o            = nc_q;
  assign rtrn_push_o     = (state_q == WAIT) && line_done_i;
  assign rtrn_tid_o      = tid_q;

endmodule

`default_nettype wire

/* verilog/credit_counter.sv */
/*
 * Request credit counter for the memory bus,
 * loaded at reset, stepped by issue and by returned credits
 */

`timescale 1ns/1ps
`default_nettype none

module credit_counter (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic issue_i,
  input  wire logic credit_i,
  output logic      has_credit_o
);

  import refill_pkg::*;

  logic [$clog2(BUS_CREDITS + 1)-1:0] count_q;

  // Issue and return in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= BUS_CREDITS[$clog2(BUS_CREDITS + 1)-1:0];
    end else begin
      case ({issue_i, credit_i})
        2'b10: begin
          count_q <= count_q - 1'b1;
        end
        2'b01: begin
          count_q <= count_q + 1'b1;
        end
        default: begin
          count_q <= count_q;
        end
      endcase
    end
  end

  assign has_credit_o = (count_q != '0);

endmodule

`default_nettype wire

/* verilog/refill_fifo.sv */
/*
 * Small circular FIFO with a payload type parameter,
 * serves as miss queue and as return queue
 */

`timescale 1ns/1ps
`default_nettype none

module refill_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = refill_pkg::QUEUE_DEPTH
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic push_i,
  input  payload_t  data_i,
  output logic      full_o,
  input  wire logic pop_i,
  output payload_t  data_o,
  output logic      empty_o
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  payload_t               mem_q [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr_q;
  logic [PTR_WIDTH-1:0]   rd_ptr_q;
  logic [CNT_WIDTH-1:0]   count_q;
  logic                   do_push;
  logic                   do_pop;

  assign full_o  = (count_q == CNT_WIDTH'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Requests against a full or empty queue are dropped here
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/refill_pkg.sv */
/*
 * Shared widths, counts and payload records of the instruction-cache
 * refill bridge: miss request and line return structs
 */

`default_nettype none

package refill_pkg;

  // Address and data widths
  localparam int ADDR_WIDTH     = 32;
  localparam int BUS_DATA_WIDTH = 32;
  localparam int LINE_WIDTH     = 128;

  // Beats needed to fill one line
  localparam int BEATS_PER_LINE = LINE_WIDTH / BUS_DATA_WIDTH;
  localparam int BEAT_CNT_WIDTH = 2;

  localparam int TID_WIDTH   = 2;
  localparam int BUS_CREDITS = 2;
  localparam int QUEUE_DEPTH = 2;

  // Miss request as queued ahead of the bus
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  nc;
    logic [TID_WIDTH-1:0]  tid;
  } miss_req_t;

  // Completed line as queued towards the core
  typedef struct packed {
    logic [LINE_WIDTH-1:0] data;
    logic [TID_WIDTH-1:0]  tid;
  } line_rtrn_t;

endpackage

`default_nettype wire
